//--- compile.f
+incdir+logic
+incdir+bench
logic/video_core_pkg.sv
logic/bridge_regs.sv
logic/pll_reconfig_seq.sv
logic/video_timing_gen.sv
logic/video_blanker.sv
logic/video_core_top.sv
bench/tb_video_core.sv

//--- bench/tb_video_core_tests.svh
/*
  directed tests and compare tasks, included inside the testbench top
  tests run in order, each starts from the mode the previous one left
*/
`ifndef TB_VIDEO_CORE_TESTS_SVH
`define TB_VIDEO_CORE_TESTS_SVH

////////////////////////////////////////
// compare tasks

task automatic report_mismatch(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
  error_count++;
  $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
endtask

task automatic compare_rd_data(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
  check_count++;
  if (got !== exp) report_mismatch(what, got, exp);
endtask

task automatic compare_mode(input string what, input video_core_pkg::video_mode_e got,
                            input video_core_pkg::video_mode_e exp);
  check_count++;
  if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
endtask

task automatic compare_rgb(input string what, input video_core_pkg::rgb_t got,
                           input video_core_pkg::rgb_t exp);
  check_count++;
  if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
endtask

task automatic compare_mgmt(input string what, input video_core_pkg::pll_mgmt_t got,
                            input video_core_pkg::pll_mgmt_t exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("Error at %0d ns: %s is %h/%h, expected %h/%h", $time, what,
             got.address, got.data, exp.address, exp.data);  // address/data
  end
endtask

task automatic compare_count(input string what, input int got, input int exp);
  check_count++;
  if (got != exp) report_mismatch(what, 32'(got), 32'(exp));
endtask

////////////////////////////////////////
// bus helpers

// 50 Hz has no table, shares the 55 Hz one
function automatic video_core_pkg::pll_mgmt_t table_entry(
    input video_core_pkg::video_mode_e mode, input int idx);
  video_core_pkg::pll_mgmt_t e;
  case (mode)
    video_core_pkg::video_57hz: e = '{1'b1, tbl_57_addr[idx], tbl_57_data[idx]};
    video_core_pkg::video_60hz: e = '{1'b1, tbl_60_addr[idx], tbl_60_data[idx]};
    default:                    e = '{1'b1, tbl_55_addr[idx], tbl_55_data[idx]};
  endcase
  return e;
endfunction

task automatic bus_write(input logic [31:0] where, input logic [31:0] value);
  @(posedge clk_74a);
  bridge <= '{addr: where, rd: 1'b0, wr: 1'b1, wr_data: value};
  @(posedge clk_74a);  // register takes it on this edge
  bridge <= '{addr: where, rd: 1'b0, wr: 1'b0, wr_data: 32'd0};
endtask

task automatic bus_read(input logic [31:0] where, output logic [31:0] value);
  @(posedge clk_74a);
  bridge <= '{addr: where, rd: 1'b1, wr: 1'b0, wr_data: 32'd0};
  @(posedge clk_74a);
  value = bridge_rd_data;  // combinational, settled since last edge
  bridge.rd <= 1'b0;
endtask

// polls the status word until busy equals level
task automatic wait_busy(input logic level, input int max_reads);
  logic [31:0] rd;
  int          n;
  n  = 0;
  rd = {31'd0, !level};
  while (rd[0] !== level && n < max_reads) begin
    bus_read(`ADDR_STATUS, rd);
    n++;
  end
  if (rd[0] !== level) begin
    error_count++;
    $display("busy flag never reached %0b within %0d status reads", level, max_reads);
  end
endtask

task automatic check_table_writes(input video_core_pkg::video_mode_e mode);
  int n;
  n = writes_seen.size();
  compare_count("PLL write count", n, `PLL_PARAM_COUNT);
  for (int i = 0; i < n && i < `PLL_PARAM_COUNT; i++) begin
    compare_mgmt("PLL write", writes_seen[i], table_entry(mode, i));
  end
endtask

task automatic retune_and_check(input video_core_pkg::video_mode_e mode);
  logic [31:0] rd;
  writes_seen.delete();
  bus_write(`ADDR_VIDEO_MODE, 32'(mode));
  wait_busy(1'b1, 4);  // pause one edge after the register
  wait_busy(1'b0, retune_cycles / 2);
  check_table_writes(mode);
  bus_read(`ADDR_VIDEO_MODE, rd);
  compare_mode("mode after retune", video_core_pkg::video_mode_e'(rd[1:0]), mode);
endtask

task automatic finish_test(input string name, input int start);
  test_count++;
  $display("test %-18s done, %0d errors", name, error_count - start);
endtask

////////////////////////////////////////
// directed tests

task automatic test_reset_values();
  int                   start;
  logic [31:0]          rd;
  video_core_pkg::rgb_t grey;
  start = error_count;
  grey  = '{red: 8'd60, green: 8'd60, blue: 8'd60};
  compare_count("outputs high in reset", reset_glitches, 0);
  bus_read(`ADDR_VIDEO_MODE, rd);
  compare_mode("mode after reset", video_core_pkg::video_mode_e'(rd[1:0]),
               video_core_pkg::video_55hz);
  bus_read(`ADDR_FILL_COLOR, rd);
  compare_rgb("fill after reset", rd[23:0], grey);
  bus_read(`ADDR_STATUS, rd);
  compare_rd_data("status after reset", rd, 32'd0);
  repeat (`RECONFIG_DELAY + 32) @(posedge clk_74a);  // longer than a settle
  compare_count("PLL writes after reset", writes_seen.size(), 0);
  finish_test("reset_values", start);
endtask

task automatic test_register_access();
  int          start;
  logic [31:0] rd;
  start = error_count;
  bus_write(`ADDR_FILL_COLOR, 32'hFF12_3456);  // top byte dropped
  fill_expected = 24'h12_3456;
  bus_read(`ADDR_FILL_COLOR, rd);
  compare_rd_data("fill colour", rd, 32'h0012_3456);
  compare_rgb("fill colour", rd[23:0], fill_expected);
  bus_write(`ADDR_VIDEO_MODE, 32'hFFFF_FFF5);  // low bits 55 Hz, no retune
  bus_read(`ADDR_VIDEO_MODE, rd);
  compare_rd_data("masked mode", rd, 32'd1);
  bus_write(32'hF200_0000, 32'hDEAD_BEEF);
  bus_read(32'hF200_0000, rd);
  compare_rd_data("unmapped read", rd, 32'd0);
  bus_read(32'h0000_0000, rd);
  compare_rd_data("unmapped read", rd, 32'd0);
  bus_read(`ADDR_FILL_COLOR, rd);
  compare_rgb("fill after stray write", rd[23:0], fill_expected);
  finish_test("register_access", start);
endtask

task automatic test_mode_switch();
  int start;
  start = error_count;
  retune_and_check(video_core_pkg::video_57hz);
  retune_and_check(video_core_pkg::video_50hz);  // expects the 55 Hz table
  finish_test("mode_switch", start);
endtask

task automatic test_pll_backpressure();
  int          start;
  logic [31:0] rd;
  start = error_count;
  backpressure_on <= 1'b1;
  retune_and_check(video_core_pkg::video_60hz);
  // PLL unlocked, writes must hold off
  lock_hold_low <= 1'b1;
  writes_seen.delete();
  bus_write(`ADDR_VIDEO_MODE, 32'(video_core_pkg::video_57hz));
  wait_busy(1'b1, 4);
  repeat (`RECONFIG_DELAY + 64) @(posedge clk_74a);
  compare_count("writes while unlocked", writes_seen.size(), 0);
  bus_read(`ADDR_STATUS, rd);
  compare_rd_data("status while unlocked", rd, 32'd1);
  lock_hold_low <= 1'b0;
  wait_busy(1'b0, retune_cycles / 2);
  check_table_writes(video_core_pkg::video_57hz);
  backpressure_on <= 1'b0;
  compare_count("writes during waitrequest", protocol_errors, 0);
  finish_test("pll_backpressure", start);
endtask

task automatic test_frame_timing();
  int                   start;
  int                   cycle;
  int                   last_hs;
  int                   hs_count;
  int                   de_in_line;
  int                   active_lines;
  logic                 seen_vs;
  logic                 rgb_bad;
  video_core_pkg::rgb_t rgb_exp;
  start   = error_count;
  seen_vs = 1'b0;
  cycle   = 0;
  while (!seen_vs && cycle <= frame_cycles) begin  // align to a frame start
    @(posedge clk_74a);
    seen_vs = video_vs;
    cycle++;
  end
  if (!seen_vs) begin
    error_count++;
    $display("no vs pulse within one frame");
  end
  seen_vs      = 1'b0;
  rgb_bad      = 1'b0;
  cycle        = 0;
  last_hs      = -1;
  hs_count     = 0;
  de_in_line   = 0;
  active_lines = 0;
  while (!seen_vs && cycle <= frame_cycles) begin
    @(posedge clk_74a);
    cycle++;
    seen_vs = video_vs;
    if (video_hs) begin
      if (last_hs >= 0) compare_count("hs spacing", cycle - last_hs, `VID_H_TOTAL);
      if (de_in_line != 0) begin  // previous line was active
        compare_count("de cycles per line", de_in_line, `VID_H_ACTIVE);
        active_lines++;
      end
      hs_count++;
      last_hs    = cycle;
      de_in_line = 0;
    end
    rgb_exp = '0;
    if (video_de) begin
      de_in_line++;
      rgb_exp = fill_expected;
    end
    if (!rgb_bad && video_rgb !== rgb_exp) begin  // report only the first
      compare_rgb("rgb against de", video_rgb, rgb_exp);
      rgb_bad = 1'b1;
    end
  end
  compare_count("vs spacing", cycle, frame_cycles);
  compare_count("hs per frame", hs_count, `VID_V_TOTAL);
  compare_count("active lines", active_lines, `VID_V_ACTIVE);
  finish_test("frame_timing", start);
endtask

task automatic test_pause_blanking();
  int   start;
  int   cycle;
  logic busy;
  logic busy_prev;
  logic seen_busy;
  logic blank_bad;
  start     = error_count;
  busy      = 1'b0;
  busy_prev = 1'b0;
  seen_busy = 1'b0;
  blank_bad = 1'b0;
  cycle     = 0;
  // start the retune inside an active line so the pause overlaps de
  while (!video_de && cycle <= frame_cycles) begin
    @(posedge clk_74a);
    cycle++;
  end
  if (!video_de) begin
    error_count++;
    $display("de never went high before the retune");
  end
  cycle = 0;
  bus_write(`ADDR_VIDEO_MODE, 32'(video_core_pkg::video_60hz));
  bridge <= '{addr: `ADDR_STATUS, rd: 1'b1, wr: 1'b0, wr_data: 32'd0};  // busy every cycle
  while (!(seen_busy && !busy) && cycle < retune_cycles) begin
    @(posedge clk_74a);
    cycle++;
    busy = bridge_rd_data[0];
    // blanker is one register behind the pause
    if (busy_prev && !blank_bad && (video_de || video_rgb !== '0)) begin
      error_count++;
      $display("Error at %0d ns: video not blanked while busy", $time);
      blank_bad = 1'b1;
    end
    busy_prev = busy;
    seen_busy = seen_busy || busy;
  end
  if (!seen_busy || busy) begin
    error_count++;
    $display("busy did not rise and clear during the retune");
  end
  bridge.rd <= 1'b0;
  cycle = 0;
  while (!video_de && cycle <= frame_cycles) begin
    @(posedge clk_74a);
    cycle++;
  end
  if (!video_de) begin
    error_count++;
    $display("de did not return within a frame after busy cleared");
  end else begin
    compare_rgb("rgb after busy", video_rgb, fill_expected);
  end
  finish_test("pause_blanking", start);
endtask

`endif

//--- bench/tb_video_core.sv
/*
  video core testbench, everything on clk_74a
  PLL model drives locked and waitrequest, random waitrequest on request
  a full run covers about three frames of video
*/
`include "video_core_defines.svh"

module tb_video_core;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int frame_cycles    = `VID_H_TOTAL * `VID_V_TOTAL;
  localparam int retune_cycles   = 2 * (`RECONFIG_DELAY + 32 * `PLL_PARAM_COUNT + 64);
  localparam int watchdog_cycles = 3 * frame_cycles + 5 * retune_cycles + 4096;

  // expected PLL writes, per mode
  localparam logic [5:0]  tbl_55_addr [`PLL_PARAM_COUNT] = `PLL_55HZ_ADDR;
  localparam logic [31:0] tbl_55_data [`PLL_PARAM_COUNT] = `PLL_55HZ_DATA;
  localparam logic [5:0]  tbl_57_addr [`PLL_PARAM_COUNT] = `PLL_57HZ_ADDR;
  localparam logic [31:0] tbl_57_data [`PLL_PARAM_COUNT] = `PLL_57HZ_DATA;
  localparam logic [5:0]  tbl_60_addr [`PLL_PARAM_COUNT] = `PLL_60HZ_ADDR;
  localparam logic [31:0] tbl_60_data [`PLL_PARAM_COUNT] = `PLL_60HZ_DATA;

  logic                        clk_74a = 1'b0;
  logic                        reset_n = 1'b0;
  video_core_pkg::bridge_bus_t bridge = '0;
  logic [31:0]                 bridge_rd_data;
  video_core_pkg::pll_mgmt_t   pll_mgmt;
  logic                        pll_waitrequest = 1'b0;
  logic                        pll_locked = 1'b0;
  video_core_pkg::rgb_t        video_rgb;
  logic                        video_de;
  logic                        video_hs;
  logic                        video_vs;

  logic                        backpressure_on = 1'b0;  // random waitrequest
  logic                        lock_hold_low = 1'b0;    // PLL stays unlocked
  video_core_pkg::pll_mgmt_t   writes_seen [$];         // transferred writes
  video_core_pkg::rgb_t        fill_expected;
  int                          protocol_errors = 0;
  int                          reset_glitches = 0;
  int                          error_count = 0;
  int                          check_count = 0;
  int                          test_count = 0;

  always #5 clk_74a = ~clk_74a;  // 10 ns

  video_core_top dut (
    .clk_74a         (clk_74a),
    .reset_n         (reset_n),
    .bridge          (bridge),
    .bridge_rd_data  (bridge_rd_data),
    .pll_mgmt        (pll_mgmt),
    .pll_waitrequest (pll_waitrequest),
    .pll_locked      (pll_locked),
    .video_rgb       (video_rgb),
    .video_de        (video_de),
    .video_hs        (video_hs),
    .video_vs        (video_vs)
  );

  ////////////////////////////////////////
  // PLL model and write monitor

  initial begin : pll_model
    void'($urandom(32'h1562e190));  // one seed for the whole run
    forever begin
      @(posedge clk_74a);
      pll_locked      <= !lock_hold_low;
      pll_waitrequest <= backpressure_on ? 1'($urandom) : 1'b0;
    end
  end

  always @(posedge clk_74a) begin
    if (reset_n && pll_mgmt.write) begin
      writes_seen.push_back(pll_mgmt);
      if (pll_waitrequest || !pll_locked) protocol_errors++;  // illegal transfer
    end
  end

  `include "tb_video_core_tests.svh"

  initial begin : watchdog
    #(watchdog_cycles * 10);
    $display("watchdog expired after %0d cycles, a test never finished", watchdog_cycles);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    repeat (16) begin
      @(posedge clk_74a);
      if (video_de || video_hs || video_vs || pll_mgmt.write) reset_glitches++;
    end
    reset_n <= 1'b1;
    test_reset_values();
    test_register_access();
    test_mode_switch();
    test_pll_backpressure();
    test_frame_timing();
    test_pause_blanking();
    $display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- logic/video_core_top.sv
/*
  video core top level, all on clk_74a
  the PLL management port is exposed as-is, the PLL itself sits outside
  video outputs lag the raster counters by two cycles
*/
module video_core_top (
  input  logic                        clk_74a,
  input  logic                        reset_n,
  input  video_core_pkg::bridge_bus_t bridge,
  output logic [31:0]                 bridge_rd_data,
  output video_core_pkg::pll_mgmt_t   pll_mgmt,
  input  logic                        pll_waitrequest,
  input  logic                        pll_locked,
  output video_core_pkg::rgb_t        video_rgb,
  output logic                        video_de,
  output logic                        video_hs,
  output logic                        video_vs
);

  video_core_pkg::video_mode_e video_mode;
  video_core_pkg::rgb_t        fill_color;
  video_core_pkg::raster_t     raster;
  logic                        reconfig_pause;

  ////////////////////////////////////////
  // host side and PLL retune

  bridge_regs u_bridge_regs (
    .clk_74a        (clk_74a),
    .reset_n        (reset_n),
    .bridge         (bridge),
    .reconfig_pause (reconfig_pause),   // reads back as busy
    .bridge_rd_data (bridge_rd_data),
    .video_mode     (video_mode),
    .fill_color     (fill_color)
  );

  pll_reconfig_seq u_pll_reconfig_seq (
    .clk_74a         (clk_74a),
    .reset_n         (reset_n),
    .video_mode      (video_mode),
    .pll_waitrequest (pll_waitrequest),
    .pll_locked      (pll_locked),
    .pll_mgmt        (pll_mgmt),
    .reconfig_pause  (reconfig_pause)
  );

  ////////////////////////////////////////
  // video path

  video_timing_gen u_video_timing_gen (
    .clk_74a (clk_74a),
    .reset_n (reset_n),
    .raster  (raster)
  );

  video_blanker u_video_blanker (
    .clk_74a        (clk_74a),
    .reset_n        (reset_n),
    .raster         (raster),
    .fill_color     (fill_color),
    .reconfig_pause (reconfig_pause),
    .video_rgb      (video_rgb),
    .video_de       (video_de),
    .video_hs       (video_hs),
    .video_vs       (video_vs)
  );

endmodule

//--- logic/video_blanker.sv
/*
  final video register stage, one cycle behind raster
  de and colour forced off while the PLL is being retuned
  rgb is zero outside de
*/
module video_blanker (
  input  logic                    clk_74a,
  input  logic                    reset_n,
  input  video_core_pkg::raster_t raster,
  input  video_core_pkg::rgb_t    fill_color,
  input  logic                    reconfig_pause,
  output video_core_pkg::rgb_t    video_rgb,
  output logic                    video_de,
  output logic                    video_hs,
  output logic                    video_vs
);

  logic de_gated;

  assign de_gated = raster.de && !reconfig_pause;  // no picture during retune

  always_ff @(posedge clk_74a or negedge reset_n) begin
    if (!reset_n) begin
      video_rgb <= '0;
      video_de  <= 1'b0;
      video_hs  <= 1'b0;
      video_vs  <= 1'b0;
    end else begin
      video_hs  <= raster.hs;  // syncs keep running while paused
      video_vs  <= raster.vs;
      video_de  <= de_gated;
      video_rgb <= de_gated ? fill_color : '0;  // inactive areas black
    end
  end

endmodule

//--- logic/video_timing_gen.sv
/*
  free running 400 x 512 raster, 320 x 240 active window
  outputs are registered, one cycle behind the counters
*/
`include "video_core_defines.svh"

module video_timing_gen (
  input  logic                    clk_74a,
  input  logic                    reset_n,
  output video_core_pkg::raster_t raster
);

  localparam int x_w = $clog2(`VID_H_TOTAL);
  localparam int y_w = $clog2(`VID_V_TOTAL);

  logic [x_w-1:0] x_count;
  logic [y_w-1:0] y_count;
  logic           h_active;
  logic           v_active;

  // active window starts after the back porch
  assign h_active = (x_count >= x_w'(`VID_H_BPORCH)) &&
                    (x_count <  x_w'(`VID_H_BPORCH + `VID_H_ACTIVE));
  assign v_active = (y_count >= y_w'(`VID_V_BPORCH)) &&
                    (y_count <  y_w'(`VID_V_BPORCH + `VID_V_ACTIVE));

  ////////////////////////////////////////
  // x and y counters

  always_ff @(posedge clk_74a or negedge reset_n) begin
    if (!reset_n) begin
      x_count <= '0;
      y_count <= '0;
    end else if (x_count == x_w'(`VID_H_TOTAL - 1)) begin
      x_count <= '0;  // end of line
      if (y_count == y_w'(`VID_V_TOTAL - 1)) begin
        y_count <= '0;  // end of frame
      end else begin
        y_count <= y_count + 1'b1;
      end
    end else begin
      x_count <= x_count + 1'b1;
    end
  end

  ////////////////////////////////////////
  // sync and de

  always_ff @(posedge clk_74a or negedge reset_n) begin
    if (!reset_n) begin
      raster <= '0;
    end else begin
      raster.vs <= (x_count == '0) && (y_count == '0);  // new frame
      raster.hs <= (x_count == x_w'(`VID_HS_POS));      // new line
      raster.de <= h_active && v_active;
    end
  end

  a_x_in_range: assert property (@(posedge clk_74a) disable iff (!reset_n)
    x_count < x_w'(`VID_H_TOTAL));

endmodule

//--- logic/pll_reconfig_seq.sv
/*
  retunes the PLL when the selected mode changes
  pauses video, waits RECONFIG_DELAY cycles, then issues nine table writes
  writes go out only while locked is high and waitrequest is low
  a mode change mid sequence is taken once the current one finishes
*/
`include "video_core_defines.svh"

module pll_reconfig_seq (
  input  logic                        clk_74a,
  input  logic                        reset_n,
  input  video_core_pkg::video_mode_e video_mode,
  input  logic                        pll_waitrequest,
  input  logic                        pll_locked,
  output video_core_pkg::pll_mgmt_t   pll_mgmt,
  output logic                        reconfig_pause
);

  localparam int idx_w = $clog2(`PLL_PARAM_COUNT);
  localparam int cnt_w = $clog2(`RECONFIG_DELAY + 1);

  localparam logic [5:0]  pll_55hz_addr [`PLL_PARAM_COUNT] = `PLL_55HZ_ADDR;
  localparam logic [31:0] pll_55hz_data [`PLL_PARAM_COUNT] = `PLL_55HZ_DATA;
  localparam logic [5:0]  pll_57hz_addr [`PLL_PARAM_COUNT] = `PLL_57HZ_ADDR;
  localparam logic [31:0] pll_57hz_data [`PLL_PARAM_COUNT] = `PLL_57HZ_DATA;
  localparam logic [5:0]  pll_60hz_addr [`PLL_PARAM_COUNT] = `PLL_60HZ_ADDR;
  localparam logic [31:0] pll_60hz_data [`PLL_PARAM_COUNT] = `PLL_60HZ_DATA;

  video_core_pkg::seq_state_e  state;
  video_core_pkg::video_mode_e mode_lat;    // mode the PLL is tuned for
  logic [cnt_w-1:0]            settle_cnt;
  logic [idx_w-1:0]            param_idx;   // next table entry
  logic                        pll_ready;
  logic [5:0]                  tbl_addr;
  logic [31:0]                 tbl_data;

  assign pll_ready = pll_locked && !pll_waitrequest;

  ////////////////////////////////////////
  // table lookup for the latched mode

  always_comb begin
    case (mode_lat)
      video_core_pkg::video_57hz: begin
        tbl_addr = pll_57hz_addr[param_idx];
        tbl_data = pll_57hz_data[param_idx];
      end
      video_core_pkg::video_60hz: begin
        tbl_addr = pll_60hz_addr[param_idx];
        tbl_data = pll_60hz_data[param_idx];
      end
      default: begin  // 50 and 55 Hz share a table
        tbl_addr = pll_55hz_addr[param_idx];
        tbl_data = pll_55hz_data[param_idx];
      end
    endcase
  end

  // write is combinational so it never overlaps a waitrequest cycle
  always_comb begin
    pll_mgmt.write   = (state == video_core_pkg::seq_write) && pll_ready;
    pll_mgmt.address = tbl_addr;
    pll_mgmt.data    = tbl_data;
  end

  ////////////////////////////////////////
  // sequencer FSM

  always_ff @(posedge clk_74a or negedge reset_n) begin
    if (!reset_n) begin
      state          <= video_core_pkg::seq_idle;
      mode_lat       <= video_core_pkg::video_55hz;
      settle_cnt     <= '0;
      param_idx      <= '0;
      reconfig_pause <= 1'b0;
    end else begin
      case (state)
        video_core_pkg::seq_idle: begin
          if (video_mode != mode_lat) begin  // new timing requested
            mode_lat       <= video_mode;
            reconfig_pause <= 1'b1;
            settle_cnt     <= '0;
            param_idx      <= '0;
            state          <= video_core_pkg::seq_settle;
          end
        end
        video_core_pkg::seq_settle: begin
          if (settle_cnt == cnt_w'(`RECONFIG_DELAY - 1)) begin
            state <= video_core_pkg::seq_write;
          end else begin
            settle_cnt <= settle_cnt + 1'b1;
          end
        end
        video_core_pkg::seq_write: begin
          if (pll_ready) begin  // this cycle's entry is transferred
            if (param_idx == idx_w'(`PLL_PARAM_COUNT - 1)) begin
              param_idx <= '0;
              state     <= video_core_pkg::seq_relock;
            end else begin
              param_idx <= param_idx + 1'b1;
            end
          end
        end
        video_core_pkg::seq_relock: begin
          if (pll_ready) begin  // unpause once locked again
            reconfig_pause <= 1'b0;
            state          <= video_core_pkg::seq_idle;
          end
        end
        default: begin
          state <= video_core_pkg::seq_idle;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // checks

  a_idx_in_range: assert property (@(posedge clk_74a) disable iff (!reset_n)
    param_idx < idx_w'(`PLL_PARAM_COUNT));

  a_pause_while_busy: assert property (@(posedge clk_74a) disable iff (!reset_n)
    (state != video_core_pkg::seq_idle) |-> reconfig_pause);

endmodule

//--- logic/bridge_regs.sv
/*
  host visible mode and fill colour registers, plus the status word
  read data is combinational from addr, unmapped addresses read zero
  mode writes keep wr_data[1:0] only
*/
`include "video_core_defines.svh"

module bridge_regs (
  input  logic                        clk_74a,
  input  logic                        reset_n,
  input  video_core_pkg::bridge_bus_t bridge,
  input  logic                        reconfig_pause,
  output logic [31:0]                 bridge_rd_data,
  output video_core_pkg::video_mode_e video_mode,
  output video_core_pkg::rgb_t        fill_color
);

  ////////////////////////////////////////
  // write side

  // mode default matches the sequencer's latched mode, so no retune at reset
  always_ff @(posedge clk_74a or negedge reset_n) begin
    if (!reset_n) begin
      video_mode       <= video_core_pkg::video_55hz;
      fill_color.red   <= 8'd60;  // flat grey
      fill_color.green <= 8'd60;
      fill_color.blue  <= 8'd60;
    end else if (bridge.wr) begin
      case (bridge.addr)
        `ADDR_VIDEO_MODE: begin
          video_mode <= video_core_pkg::video_mode_e'(bridge.wr_data[1:0]);
        end
        `ADDR_FILL_COLOR: begin
          fill_color <= bridge.wr_data[23:0];  // r in 23:16, b in 7:0
        end
        default: begin
          // status and unmapped addresses ignore writes
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // read side

  always_comb begin
    case (bridge.addr)
      `ADDR_VIDEO_MODE: begin
        bridge_rd_data = {30'd0, video_mode};
      end
      `ADDR_FILL_COLOR: begin
        bridge_rd_data = {8'd0, fill_color};
      end
      `ADDR_STATUS: begin
        bridge_rd_data = {31'd0, reconfig_pause};  // busy while retuning
      end
      default: begin
        bridge_rd_data = 32'd0;
      end
    endcase
  end

endmodule

//--- logic/video_core_pkg.sv
/*
  types shared by the video core blocks
  everything runs on clk_74a, no second clock domain
*/
package video_core_pkg;

  ////////////////////////////////////////
  // enums

  // refresh modes as written to the mode register
  typedef enum logic [1:0] {
    video_50hz = 2'd0,  // reuses the 55 Hz PLL table
    video_55hz = 2'd1,  // reset default
    video_57hz = 2'd2,
    video_60hz = 2'd3
  } video_mode_e;

  // reconfiguration sequencer states
  typedef enum logic [1:0] {
    seq_idle   = 2'd0,  // watching for a mode change
    seq_settle = 2'd1,  // paused, waiting out the delay
    seq_write  = 2'd2,  // streaming the table
    seq_relock = 2'd3   // last write done, waiting for lock
  } seq_state_e;

  ////////////////////////////////////////
  // packed structs

  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb_t;

  // host bridge, synchronous to clk_74a
  typedef struct packed {
    logic [31:0] addr;
    logic        rd;
    logic        wr;       // one write per cycle held high
    logic [31:0] wr_data;
  } bridge_bus_t;

  // PLL management write port, waitrequest travels separately
  typedef struct packed {
    logic        write;
    logic [5:0]  address;
    logic [31:0] data;
  } pll_mgmt_t;

  typedef struct packed {
    logic de;
    logic hs;
    logic vs;
  } raster_t;

endpackage

//--- logic/video_core_defines.svh
/*
  raster, bridge map and PLL reconfiguration constants
  PLL tables list nine address/data writes in issue order, index 0 first
  the 50 Hz mode has no table of its own and reuses the 55 Hz one
*/
`ifndef VIDEO_CORE_DEFINES_SVH
`define VIDEO_CORE_DEFINES_SVH

////////////////////////////////////////
// raster geometry, in clk_74a cycles

`define VID_H_TOTAL  400  // cycles per line
`define VID_H_ACTIVE 320
`define VID_H_BPORCH 10
`define VID_V_TOTAL  512  // lines per frame
`define VID_V_ACTIVE 240
`define VID_V_BPORCH 10
`define VID_HS_POS   3    // hs a little after vs, never on the same cycle

////////////////////////////////////////
// bridge register map

`define ADDR_VIDEO_MODE 32'hF100_0000
`define ADDR_FILL_COLOR 32'hF300_0000
`define ADDR_STATUS     32'hFA00_0000  // bit 0 busy

////////////////////////////////////////
// PLL reconfiguration

`define PLL_PARAM_COUNT 9
`define RECONFIG_DELAY  255  // settle cycles before the first write

// waitrequest mode, M, N, four C counters, bandwidth, start
`define PLL_55HZ_ADDR '{6'h0, 6'h4, 6'h3, 6'h5, 6'h5, 6'h5, 6'h5, 6'h8, 6'h2}
`define PLL_55HZ_DATA '{32'h0, 32'h4040, 32'h20605, 32'h20504, 32'h60E0D, \
                        32'h83636, 32'hC3636, 32'h3, 32'h0}

`define PLL_57HZ_ADDR '{6'h0, 6'h4, 6'h3, 6'h5, 6'h5, 6'h5, 6'h5, 6'h8, 6'h2}
`define PLL_57HZ_DATA '{32'h0, 32'h26F6E, 32'h20605, 32'h20807, 32'h61716, \
                        32'h85A5A, 32'hC5A5A, 32'h2, 32'h0}

`define PLL_60HZ_ADDR '{6'h0, 6'h4, 6'h3, 6'h5, 6'h5, 6'h5, 6'h5, 6'h8, 6'h2}
`define PLL_60HZ_DATA '{32'h0, 32'h24746, 32'h505, 32'h505, 32'h40F0F, \
                        32'h83C3C, 32'hC3C3C, 32'h3, 32'h0}

`endif
